// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= synth_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run, check $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

$(BUILD_DIR)/V$(TOP): $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

test: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -q "^STATUS: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== flist.f ====
+incdir+src
src/synth_pkg.sv
src/uart_cmd_rx.sv
src/osc_bank.sv
src/i2s_tx.sv
src/synth_top.sv
verification/tb_clk_gen.sv
verification/synth_checker.sv
verification/synth_props.sv
verification/synth_tb.sv

// ==== src/i2s_tx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "synth_settings.svh"

module i2s_tx
    import synth_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    ena,
    input  sample_t sample,
    output logic    sck,
    output logic    ws,
    output logic    sd
);

    localparam int                CNT_W    = $clog2(`I2S_WORD_BITS);
    localparam logic [CNT_W-1:0]  LAST_BIT = CNT_W'(`I2S_WORD_BITS - 1);

    logic [CNT_W-1:0]          bit_cnt;
    logic [`I2S_WORD_BITS-1:0] word;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sck     <= 1'b0;
            ws      <= 1'b0;
            sd      <= 1'b0;
            bit_cnt <= '0;
            word    <= '0;
        end else if (ena) begin
            sck <= ~sck;  // Bit clock at half the system clock
            if (sck) begin
                // sd only moves as sck falls, stable over the high phase
                bit_cnt <= bit_cnt + 1'b1;
                sd      <= word[LAST_BIT - bit_cnt];  // MSB first
                if (bit_cnt == LAST_BIT) begin
                    ws   <= ~ws;
                    word <= {sample, sample};  // Same byte on both halves
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== src/osc_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "synth_settings.svh"

module osc_bank
    import synth_pkg::*;
(
    input  logic    clk,
    input  logic    rst_n,
    input  logic    ena,
    input  note_t   note,
    input  wave_e   wave,
    input  logic    noise_en,
    output sample_t sample
);

    localparam logic [`DIV_W-1:0] DIV_TABLE [`NUM_NOTES] = '{
        // Octave 2, ten times the plain ratio as in the original tuning
        21'd1915712,  // C2
        21'd1803586,  // C#2
        21'd1702624,  // D2
        21'd1607142,  // D#2
        21'd1515152,  // E2
        21'd1431731,  // F2
        21'd1351351,  // F#2
        21'd1275510,  // G2
        21'd1204819,  // G#2
        21'd1136364,  // A2
        21'd1075268,  // A#2
        21'd1017340,  // B2
        // Octave 3
        21'd95786,    // C3
        21'd90180,    // C#3
        21'd85131,    // D3
        21'd80357,    // D#3
        21'd75758,    // E3
        21'd71586,    // F3
        21'd67567,    // F#3
        21'd63775,    // G3
        21'd60241,    // G#3
        21'd56818,    // A3
        21'd53763,    // A#3
        21'd50867,    // B3
        // Octave 4
        21'd47878,    // C4
        21'd45090,    // C#4
        21'd42566,    // D4
        21'd40178,    // D#4
        21'd37878,    // E4
        21'd35793,    // F4
        21'd33783,    // F#4
        21'd31888,    // G4
        21'd30120,    // G#4
        21'd28409,    // A4
        21'd26881,    // A#4
        21'd25434     // B4
    };

    logic [`DIV_W-1:0]    div_val;
    logic [`DIV_W-1:0]    div_cnt;
    logic                 div_step;
    logic [`SAMPLE_W-1:0] saw_cnt;
    logic [`SAMPLE_W-1:0] tri_cnt;
    logic                 tri_down;
    logic                 sqr_state;
    logic [15:0]          lfsr;
    logic                 lfsr_fb;
    sample_t              tone;

    // Receiver never selects past the table, fall back to note 0
    assign div_val = (note < `NUM_NOTES) ? DIV_TABLE[note] : DIV_TABLE[0];

    // >= so a switch to a shorter divider wraps at once
    assign div_step = ena && (div_cnt >= div_val);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            div_cnt <= '0;
        end else if (ena) begin
            if (div_step) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    // All three tones advance on the shared step
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            saw_cnt   <= '0;
            tri_cnt   <= '0;
            tri_down  <= 1'b0;
            sqr_state <= 1'b0;
        end else if (div_step) begin
            saw_cnt   <= saw_cnt + 1'b1;  // Wraps at 255
            sqr_state <= ~sqr_state;
            if (!tri_down) begin
                if (tri_cnt == '1) begin
                    tri_down <= 1'b1;  // Hold one step at the top
                end else begin
                    tri_cnt <= tri_cnt + 1'b1;
                end
            end else begin
                if (tri_cnt == '0) begin
                    tri_down <= 1'b0;  // Hold one step at the bottom
                end else begin
                    tri_cnt <= tri_cnt - 1'b1;
                end
            end
        end
    end

    // Taps 15, 13, 12, 10
    assign lfsr_fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];

    // Free runs while enabled so noise is ready when selected
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            lfsr <= `LFSR_SEED;
        end else if (ena) begin
            lfsr <= {lfsr[14:0], lfsr_fb};
        end
    end

    always_comb begin
        case (wave)
            WAVE_TRI: tone = tri_cnt;
            WAVE_SAW: tone = saw_cnt;
            WAVE_SQR: tone = {`SAMPLE_W{sqr_state}};  // Full scale or zero
            default:  tone = '0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sample <= '0;
        end else begin
            sample <= noise_en ? lfsr[15:8] : tone;  // Noise overrides the tone
        end
    end

endmodule

`default_nettype wire

// ==== src/synth_pkg.sv ====
`default_nettype none

`include "synth_settings.svh"

package synth_pkg;

    // One audio sample, unsigned
    typedef logic [`SAMPLE_W-1:0] sample_t;

    // Index into the note divider table
    typedef logic [`NOTE_W-1:0] note_t;

    // Tone selection
    typedef enum logic [1:0] {
        WAVE_TRI = 2'd0,
        WAVE_SAW = 2'd1,
        WAVE_SQR = 2'd2
    } wave_e;

endpackage

`default_nettype wire

// ==== src/synth_settings.svh ====
`ifndef SYNTH_SETTINGS_SVH
`define SYNTH_SETTINGS_SVH

// Sample and note widths
`define SAMPLE_W        8
`define NOTE_W          6
`define NUM_NOTES       36

// Divider counter must hold the C2 value of 1915712
`define DIV_W           21

// I2S word, sample replicated into both bytes
`define I2S_WORD_BITS   16

// Noise register reset value
`define LFSR_SEED       16'hACE1

// Command characters
`define CMD_TRI         8'h54   // 'T'
`define CMD_SAW         8'h53   // 'S'
`define CMD_SQR         8'h51   // 'Q'
`define CMD_NOISE_ON    8'h4E   // 'N'
`define CMD_NOISE_OFF   8'h46   // 'F'
`define CMD_SINE        8'h57   // 'W', no sine table, byte is ignored

// Note character ranges
`define CHAR_DIGIT_LO   8'h30   // '0'
`define CHAR_DIGIT_HI   8'h39   // '9'
`define CHAR_UPPER_LO   8'h41   // 'A'
`define CHAR_UPPER_HI   8'h5A   // 'Z'

`endif

// ==== src/synth_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module synth_top
    import synth_pkg::*;
(
    input  logic clk,
    input  logic rst_n,
    input  logic ena,
    input  logic rx,
    output logic sck,
    output logic ws,
    output logic sd
);

    note_t   note;
    wave_e   wave;
    logic    noise_en;
    sample_t sample;

    uart_cmd_rx u_rx (
        .clk      (clk),
        .rst_n    (rst_n),
        .rx       (rx),
        .note     (note),
        .wave     (wave),
        .noise_en (noise_en)
    );

    osc_bank u_osc (
        .clk      (clk),
        .rst_n    (rst_n),
        .ena      (ena),
        .note     (note),
        .wave     (wave),
        .noise_en (noise_en),
        .sample   (sample)
    );

    i2s_tx u_i2s (
        .clk    (clk),
        .rst_n  (rst_n),
        .ena    (ena),
        .sample (sample),
        .sck    (sck),
        .ws     (ws),
        .sd     (sd)
    );

endmodule

`default_nettype wire

// ==== src/uart_cmd_rx.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "synth_settings.svh"

module uart_cmd_rx
    import synth_pkg::*;
(
    input  logic  clk,
    input  logic  rst_n,
    input  logic  rx,
    output note_t note,
    output wave_e wave,
    output logic  noise_en
);

    typedef enum logic [1:0] {
        ST_IDLE   = 2'd0,
        ST_RECV   = 2'd1,
        ST_DECODE = 2'd2
    } state_e;

    state_e     state;
    logic       rx_meta;
    logic       rx_sync;
    logic       rx_last;
    logic       start_edge;
    logic [2:0] bit_cnt;
    logic [7:0] rx_byte;

    // Two-flop synchronizer plus edge history, idle high
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rx_meta <= 1'b1;
            rx_sync <= 1'b1;
            rx_last <= 1'b1;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            rx_last <= rx_sync;
        end
    end

    assign start_edge = rx_last & ~rx_sync;  // Falling edge of start cycle

    // LSB arrives first, shift in from the top
    always_ff @(posedge clk) begin
        if (state == ST_RECV) begin
            rx_byte <= {rx_sync, rx_byte[7:1]};
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= ST_IDLE;
            bit_cnt  <= 3'd0;
            note     <= '0;
            wave     <= WAVE_TRI;
            noise_en <= 1'b0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start_edge) begin
                        bit_cnt <= 3'd0;
                        state   <= ST_RECV;
                    end
                end
                ST_RECV: begin
                    bit_cnt <= bit_cnt + 3'd1;  // Wraps back to 0 after bit 7
                    if (bit_cnt == 3'd7) begin
                        state <= ST_DECODE;
                    end
                end
                ST_DECODE: begin
                    case (rx_byte)
                        `CMD_TRI:       wave     <= WAVE_TRI;
                        `CMD_SAW:       wave     <= WAVE_SAW;
                        `CMD_SQR:       wave     <= WAVE_SQR;
                        `CMD_NOISE_ON:  noise_en <= 1'b1;
                        `CMD_NOISE_OFF: noise_en <= 1'b0;
                        `CMD_SINE:      ;  // Capital, but must not pick a note
                        default: begin
                            if (rx_byte >= `CHAR_DIGIT_LO && rx_byte <= `CHAR_DIGIT_HI) begin
                                note <= note_t'(rx_byte - `CHAR_DIGIT_LO);  // Notes 0-9
                            end else if (rx_byte >= `CHAR_UPPER_LO &&
                                         rx_byte <= `CHAR_UPPER_HI) begin
                                note <= note_t'(rx_byte - 8'h37);  // 'A' maps to 10
                            end
                        end
                    endcase
                    state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== verification/synth_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module synth_checker
    import synth_pkg::*;
(
    input  logic       clk,
    input  logic       rst_n,
    input  logic       sck,
    input  logic       ws,
    input  logic       sd,
    input  logic       cmd_stb,
    input  logic [7:0] cmd_byte,
    output int         err_count,
    output int         word_count
);

    // Divider per note, C2 to B4
    int divs [36] = '{1915712, 1803586, 1702624, 1607142, 1515152, 1431731,
                      1351351, 1275510, 1204819, 1136364, 1075268, 1017340,
                      95786, 90180, 85131, 80357, 75758, 71586,
                      67567, 63775, 60241, 56818, 53763, 50867,
                      47878, 45090, 42566, 40178, 37878, 35793,
                      33783, 31888, 30120, 28409, 26881, 25434};

    wave_e        exp_wave = WAVE_TRI;
    logic         exp_noise = 1'b0;
    int           exp_note = 0;
    int           skip = 3;  // Words to drop while a change settles
    logic         prev_rst_n = 1'b1;
    logic         ws_last = 1'b0;
    logic         bit_ws = 1'b0;
    bit           ws_seen = 0;
    bit           started = 0;
    int           ws_cycles = 0;
    logic [15:0]  shreg = '0;
    bit           have_last = 0;
    logic [7:0]   last_val = '0;
    int           hold = 0;
    bit           seen_lo = 0;
    bit           seen_hi = 0;
    bit [255:0]   seen_mask = '0;
    int           win_cnt = 0;

    initial begin
        err_count  = 0;
        word_count = 0;
    end

    task automatic report_value(input string name, input int exp, input int act);
        $display("FAIL %s: expected %0h, actual %0h", name, exp, act);
        err_count++;
    endtask

    task automatic apply_cmd(input logic [7:0] b);
        if (!exp_noise && exp_wave == WAVE_SQR && !(seen_lo && seen_hi)) begin
            $display("Square phase ended without both full-scale and zero words");
            err_count++;
        end
        case (b)
            8'h54: exp_wave = WAVE_TRI;   // T
            8'h53: exp_wave = WAVE_SAW;   // S
            8'h51: exp_wave = WAVE_SQR;   // Q
            8'h4E: exp_noise = 1'b1;      // N
            8'h46: exp_noise = 1'b0;      // F
            8'h57: ;                      // W has no tone
            default: begin
                if (b >= 8'h30 && b <= 8'h39) exp_note = int'(b) - 48;
                else if (b >= 8'h41 && b <= 8'h5A) exp_note = int'(b) - 55;
            end
        endcase
        skip      = 3;
        have_last = 0;
        hold      = 0;
        seen_lo   = 0;
        seen_hi   = 0;
        seen_mask = '0;
        win_cnt   = 0;
    endtask

    task automatic check_word(input logic [15:0] w);
        logic [7:0] v;
        int         limit;
        int         distinct;
        v = w[7:0];
        limit = (divs[exp_note] + 1 + 31) / 32 + 2;
        word_count++;
        if (skip > 0) begin
            skip--;
            return;
        end
        if (w[15:8] != w[7:0]) report_value("bytes_equal", int'(w[7:0]), int'(w[15:8]));
        if (exp_noise) begin
            seen_mask[v] = 1'b1;
            win_cnt++;
            if (win_cnt == 32) begin
                distinct = 0;
                for (int i = 0; i < 256; i++) distinct += int'(seen_mask[i]);
                if (distinct < 8) begin
                    $display("Noise gave only %0d distinct values in 32 words", distinct);
                    err_count++;
                end
                seen_mask = '0;
                win_cnt   = 0;
            end
        end else begin
            case (exp_wave)
                WAVE_SQR: begin
                    if (v != 8'h00 && v != 8'hFF) report_value("square", 255, int'(v));
                    if (v == 8'h00) seen_lo = 1;
                    if (v == 8'hFF) seen_hi = 1;
                end
                WAVE_SAW: begin
                    if (have_last && v != last_val && v != last_val + 8'd1) begin
                        report_value("sawtooth", int'(8'(last_val + 8'd1)), int'(v));
                    end
                    hold = (have_last && v == last_val) ? hold + 1 : 1;
                    if (hold > limit) begin
                        $display("Sawtooth value %0h held for more than %0d words", v, limit);
                        err_count++;
                        hold = 0;
                    end
                end
                default: begin
                    if (have_last && v != last_val &&
                        (int'(v) - int'(last_val) > 1 || int'(last_val) - int'(v) > 1)) begin
                        report_value("triangle", (v > last_val) ? int'(last_val) + 1
                                                                : int'(last_val) - 1, int'(v));
                    end
                    hold = (have_last && v == last_val) ? hold + 1 : 1;
                    if (hold > 2 * limit) begin  // Ends hold for an extra step
                        $display("Triangle value %0h held for more than %0d words",
                                 v, 2 * limit);
                        err_count++;
                        hold = 0;
                    end
                end
            endcase
        end
        last_val  = v;
        have_last = 1;
    endtask

    // Old register values at each rising edge, so no race with the DUT
    always @(posedge clk) begin
        if (!prev_rst_n && (sck !== 1'b0 || ws !== 1'b0 || sd !== 1'b0)) begin
            $display("I2S outputs not low during or right after reset");
            err_count++;
        end
        if (rst_n && prev_rst_n) begin
            ws_cycles++;
            if (ws != ws_last) begin
                if (ws_seen && ws_cycles != 32) begin
                    $display("ws toggled after %0d clocks instead of 32", ws_cycles);
                    err_count++;
                end
                ws_seen   = 1;
                ws_cycles = 0;
            end
            if (sck) begin  // sd held over the high phase
                shreg = {shreg[14:0], sd};
                if (ws != bit_ws) begin
                    if (started) check_word(shreg);  // LSB arrives after the ws toggle
                    started = 1;
                end
                bit_ws = ws;
            end
        end
        if (cmd_stb) apply_cmd(cmd_byte);
        ws_last    = ws;
        prev_rst_n = rst_n;
    end

endmodule

`default_nettype wire

// ==== verification/synth_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module synth_props (
    input logic clk,
    input logic rst_n,
    input logic ena,
    input logic sck,
    input logic ws,
    input logic sd
);

    a_sck_toggles: assert property (@(posedge clk) disable iff (!rst_n)
        ena |=> (sck != $past(sck)))
        else $error("sck missed a toggle");

    a_ws_after_sck_high: assert property (@(posedge clk) disable iff (!rst_n)
        $changed(ws) |-> $past(sck))
        else $error("ws moved outside a falling sck");

    a_sd_stable_high: assert property (@(posedge clk) disable iff (!rst_n)
        sck |-> $stable(sd))
        else $error("sd moved while sck high");

endmodule

bind i2s_tx synth_props props0 (
    .clk   (clk),
    .rst_n (rst_n),
    .ena   (ena),
    .sck   (sck),
    .ws    (ws),
    .sd    (sd)
);

`default_nettype wire

// ==== verification/synth_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module synth_tb;

    localparam int PHASE_TONE  = 3 * 25435 + 2000;  // Three steps of note Z
    localparam int PHASE_NOISE = 4000;
    localparam int LIMIT       = 5 * PHASE_TONE + PHASE_NOISE + 20000;

    logic       clk;
    logic       rst_n;
    logic       ena;
    logic       rx;
    logic       sck;
    logic       ws;
    logic       sd;
    logic       cmd_stb;
    logic [7:0] cmd_byte;
    int         err_count;
    int         word_count;
    int         seed = 32'h0ff71bc0;
    int         cycle_count = 0;

    tb_clk_gen clk0 (.clk(clk), .rst_n(rst_n));

    synth_top dut0 (
        .clk   (clk),
        .rst_n (rst_n),
        .ena   (ena),
        .rx    (rx),
        .sck   (sck),
        .ws    (ws),
        .sd    (sd)
    );

    synth_checker chk0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .sck        (sck),
        .ws         (ws),
        .sd         (sd),
        .cmd_stb    (cmd_stb),
        .cmd_byte   (cmd_byte),
        .err_count  (err_count),
        .word_count (word_count)
    );

    task automatic wait_cycles(input int n);
        repeat (n) @(negedge clk);
    endtask

    // Start cycle, eight data cycles LSB first, then a random idle gap
    task automatic send_byte(input logic [7:0] b);
        int gap;
        gap = 2 + ($random(seed) & 15);
        @(negedge clk) rx = 1'b0;
        for (int i = 0; i < 8; i++) begin
            @(negedge clk) rx = b[i];
        end
        @(negedge clk) rx = 1'b1;
        wait_cycles(gap);
        @(negedge clk);
        cmd_byte = b;
        cmd_stb  = 1'b1;
        @(negedge clk) cmd_stb = 1'b0;
    endtask

    initial begin
        rx       = 1'b1;
        ena      = 1'b1;
        cmd_stb  = 1'b0;
        cmd_byte = 8'h00;
        @(posedge rst_n);
        wait_cycles(40);
        send_byte("Z");
        send_byte("Q");
        wait_cycles(PHASE_TONE);
        send_byte("S");
        send_byte("W");
        wait_cycles(PHASE_TONE);
        send_byte("T");
        wait_cycles(PHASE_TONE);
        send_byte("Q");  // Square stays selected under noise
        wait_cycles(PHASE_TONE);
        send_byte("N");
        wait_cycles(PHASE_NOISE);
        send_byte("F");
        wait_cycles(PHASE_TONE);
        send_byte(8'h00);  // Ignored byte, closes the last square phase
        wait_cycles(100);
        $display("Errors: %0d, words decoded: %0d", err_count, word_count);
        if (err_count == 0 && word_count > 100) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > LIMIT) begin
            $display("Timeout, run went past %0d cycles", LIMIT);
            $display("Errors: %0d, words decoded: %0d", err_count, word_count);
            $display("STATUS: FAIL");
            $finish;
        end
    end

endmodule

`default_nettype wire

// ==== verification/tb_clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
    output logic clk,
    output logic rst_n
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;  // 100 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        @(negedge clk) rst_n = 1'b1;
    end

endmodule

`default_nettype wire
